//--- source/dbg_trigger_pkg.sv
// Debug trigger unit package holding the trigger count, the tdata1 field map, enums and bus structs
`default_nettype none

package dbg_trigger_pkg;

  //////////////////////////////
  // Sizes and reset values
  //////////////////////////////

  localparam int unsigned NUM_TRIGGERS = 4;               // Number of trigger slots
  localparam int unsigned TSEL_W       = 2;               // Trigger index width
  localparam logic [31:0] TDATA1_RST_VAL = 32'hF800_0000; // Disabled type with dmode set

  //////////////////////////////
  // tdata1 field positions
  //////////////////////////////

  localparam int unsigned TTYPE_HI  = 31;  // Trigger type
  localparam int unsigned TTYPE_LO  = 28;
  localparam int unsigned DMODE_BIT = 27;  // Only debug mode may write
  localparam int unsigned ACTION_HI = 15;  // Action on hit
  localparam int unsigned ACTION_LO = 12;
  localparam int unsigned MATCH_HI  = 10;  // Compare mode against tdata2
  localparam int unsigned MATCH_LO  = 7;
  localparam int unsigned M_BIT     = 6;   // Enable in machine mode
  localparam int unsigned U_BIT     = 3;   // Enable in user mode
  localparam int unsigned EXEC_BIT  = 2;   // Instruction address trigger
  localparam int unsigned STORE_BIT = 1;   // Store address trigger
  localparam int unsigned LOAD_BIT  = 0;   // Load address trigger

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Trigger types that survive legalization
  typedef enum logic [3:0] {
    TTYPE_MCONTROL6 = 4'h6,
    TTYPE_DISABLED  = 4'hF
  } ttype_e;

  // Supported match modes, anything else is legalized to equal
  typedef enum logic [3:0] {
    MATCH_EQ = 4'h0,
    MATCH_GE = 4'h2,
    MATCH_LT = 4'h3
  } match_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  //////////////////////////////
  // Buses
  //////////////////////////////

  // Raw CSR write, at most one strobe per cycle
  typedef struct packed {
    logic        tselect_we;
    logic        tdata1_we;
    logic        tdata2_we;
    logic [31:0] wdata;
  } csr_wr_t;

  // Legalized write routed to one slot
  typedef struct packed {
    logic        tdata1_we;
    logic        tdata2_we;
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } slot_wr_t;

  typedef struct packed {
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } slot_regs_t;

  typedef struct packed {
    logic [31:0] tselect;  // Zero-extended index
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } csr_rd_t;

  // IF stage fetch
  typedef struct packed {
    logic [31:0] pc;
    logic        ptr;      // Pointer fetch, never triggers
    priv_e       priv;
  } fetch_t;

  // EX stage LSU request
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic        we;       // High for store
    logic [3:0]  be;
    priv_e       priv;
  } lsu_req_t;

endpackage

`default_nettype wire

//--- source/trigger_csr_write.sv
// Trigger CSR write stage that holds tselect, legalizes tdata1 and routes writes to the selected slot
`default_nettype none

module trigger_csr_write
  import dbg_trigger_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset_i,
  input  wire csr_wr_t                    csr_wr_i,
  output slot_wr_t [NUM_TRIGGERS-1:0]     slot_wr_o,   // One write port per slot
  output logic     [TSEL_W-1:0]           tselect_o
);

  logic [TSEL_W-1:0] tselect_q;
  logic [3:0]        wr_match;     // Match field of the write data
  match_e            match_legal;
  logic [31:0]       tdata1_legal;

  //////////////////////////////
  // tselect register
  //////////////////////////////

  // WARL index where out of range writes keep the old value
  always_ff @(posedge clk) begin
    if (reset_i) begin
      tselect_q <= '0;
    end else if (csr_wr_i.tselect_we && (csr_wr_i.wdata < NUM_TRIGGERS)) begin
      tselect_q <= csr_wr_i.wdata[TSEL_W-1:0];
    end
  end

  assign tselect_o = tselect_q;

  //////////////////////////////
  // tdata1 legalization
  //////////////////////////////

  assign wr_match = csr_wr_i.wdata[MATCH_HI:MATCH_LO];

  always_comb begin
    case (wr_match)
      MATCH_EQ, MATCH_GE, MATCH_LT: match_legal = match_e'(wr_match);
      default:                      match_legal = MATCH_EQ;  // Unsupported mode
    endcase
  end

  always_comb begin
    tdata1_legal = TDATA1_RST_VAL;  // Any other type becomes disabled
    if (csr_wr_i.wdata[TTYPE_HI:TTYPE_LO] == TTYPE_MCONTROL6) begin
      tdata1_legal                      = '0;              // s bit and reserved fields zero
      tdata1_legal[TTYPE_HI:TTYPE_LO]   = TTYPE_MCONTROL6;
      tdata1_legal[DMODE_BIT]           = 1'b1;            // Debug mode access only
      tdata1_legal[ACTION_HI:ACTION_LO] = 4'h1;            // Enter debug on hit
      tdata1_legal[MATCH_HI:MATCH_LO]   = match_legal;
      tdata1_legal[M_BIT]               = csr_wr_i.wdata[M_BIT];
      tdata1_legal[U_BIT]               = csr_wr_i.wdata[U_BIT];
      tdata1_legal[EXEC_BIT]            = csr_wr_i.wdata[EXEC_BIT];
      tdata1_legal[STORE_BIT]           = csr_wr_i.wdata[STORE_BIT];
      tdata1_legal[LOAD_BIT]            = csr_wr_i.wdata[LOAD_BIT];
    end
  end

  //////////////////////////////
  // Slot routing
  //////////////////////////////

  // Only the slot named by tselect sees the strobes
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      slot_wr_o[i].tdata1_we = csr_wr_i.tdata1_we && (tselect_q == TSEL_W'(i));
      slot_wr_o[i].tdata2_we = csr_wr_i.tdata2_we && (tselect_q == TSEL_W'(i));
      slot_wr_o[i].tdata1    = tdata1_legal;
      slot_wr_o[i].tdata2    = csr_wr_i.wdata;  // tdata2 takes any value
    end
  end

  // CSR port issues at most one write per cycle
  a_one_strobe : assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({csr_wr_i.tselect_we, csr_wr_i.tdata1_we, csr_wr_i.tdata2_we}))
    else $error("More than one trigger CSR strobe in a cycle");

  // Index beyond the last slot never reaches tselect
  a_tselect_range : assert property (@(posedge clk) disable iff (reset_i)
    (csr_wr_i.tselect_we && (csr_wr_i.wdata >= NUM_TRIGGERS)) |=> $stable(tselect_q))
    else $error("tselect changed on an out of range write");

endmodule

`default_nettype wire

//--- source/trigger_slot.sv
// Single debug trigger, stores tdata1 and tdata2 and computes instruction and load/store hits
`default_nettype none

module trigger_slot
  import dbg_trigger_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset_i,
  input  wire slot_wr_t   slot_wr_i,
  input  wire fetch_t     fetch_i,
  input  wire lsu_req_t   lsu_i,
  input  wire logic       debug_mode_i,
  output slot_regs_t      regs_o,
  output logic            if_hit_o,       // Instruction address hit
  output logic            ex_hit_o        // Load/store address hit
);

  logic [31:0] tdata1_q;
  logic [31:0] tdata2_q;
  ttype_e      ttype;
  match_e      match_mode;
  logic        mc6_active;       // Slot holds an mcontrol6 trigger
  logic        if_addr_match;
  logic        lsu_addr_match;
  logic        lsu_access_en;    // Load or store kind enabled for this request
  logic        lsu_byte_hit;
  logic [1:0]  lsu_hi_lsb;       // Highest enabled byte index
  logic [1:0]  lsu_lo_lsb;       // Lowest enabled byte index
  logic [31:0] lsu_addr_hi;
  logic [31:0] lsu_addr_lo;

  // Privilege filter shared by the IF and EX checks
  function automatic logic priv_enabled(input logic m_en, input logic u_en, input priv_e priv);
    return (m_en && (priv == PRIV_M)) || (u_en && (priv == PRIV_U));
  endfunction

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tdata1_q <= TDATA1_RST_VAL;
      tdata2_q <= '0;
    end else begin
      if (slot_wr_i.tdata1_we) begin
        tdata1_q <= slot_wr_i.tdata1;  // Already legalized
      end
      if (slot_wr_i.tdata2_we) begin
        tdata2_q <= slot_wr_i.tdata2;
      end
    end
  end

  assign regs_o.tdata1 = tdata1_q;
  assign regs_o.tdata2 = tdata2_q;

  assign ttype      = ttype_e'(tdata1_q[TTYPE_HI:TTYPE_LO]);
  assign match_mode = match_e'(tdata1_q[MATCH_HI:MATCH_LO]);
  assign mc6_active = (ttype == TTYPE_MCONTROL6);

  //////////////////////////////
  // Instruction address hit
  //////////////////////////////

  always_comb begin
    case (match_mode)
      MATCH_EQ: if_addr_match = (fetch_i.pc == tdata2_q);
      MATCH_GE: if_addr_match = (fetch_i.pc >= tdata2_q);
      MATCH_LT: if_addr_match = (fetch_i.pc <  tdata2_q);
      default:  if_addr_match = 1'b0;
    endcase
  end

  assign if_hit_o = mc6_active && tdata1_q[EXEC_BIT] && !fetch_i.ptr && !debug_mode_i &&
                    priv_enabled(tdata1_q[M_BIT], tdata1_q[U_BIT], fetch_i.priv) &&
                    if_addr_match;

  //////////////////////////////
  // Load/store address hit
  //////////////////////////////

  // Byte span of the access from the byte enables
  always_comb begin
    lsu_hi_lsb = 2'b00;
    lsu_lo_lsb = 2'b00;
    for (int b = 0; b < 4; b++) begin
      if (lsu_i.be[b]) begin
        lsu_hi_lsb = 2'(b);     // Last set bit wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_i.be[b]) begin
        lsu_lo_lsb = 2'(b);     // First set bit wins
      end
    end
  end

  assign lsu_addr_hi  = {lsu_i.addr[31:2], lsu_hi_lsb};
  assign lsu_addr_lo  = {lsu_i.addr[31:2], lsu_lo_lsb};
  assign lsu_byte_hit = |(lsu_i.be & (4'b0001 << tdata2_q[1:0]));  // Byte of tdata2 accessed

  always_comb begin
    case (match_mode)
      MATCH_EQ: lsu_addr_match = (lsu_i.addr[31:2] == tdata2_q[31:2]) && lsu_byte_hit;
      MATCH_GE: lsu_addr_match = (lsu_addr_hi >= tdata2_q);
      MATCH_LT: lsu_addr_match = (lsu_addr_lo <  tdata2_q);
      default:  lsu_addr_match = 1'b0;
    endcase
  end

  assign lsu_access_en = lsu_i.valid &&
                         ((tdata1_q[LOAD_BIT] && !lsu_i.we) || (tdata1_q[STORE_BIT] && lsu_i.we));

  assign ex_hit_o = mc6_active && lsu_access_en && !debug_mode_i &&
                    priv_enabled(tdata1_q[M_BIT], tdata1_q[U_BIT], lsu_i.priv) &&
                    lsu_addr_match;

  // Legalization upstream leaves only two types in the slot
  a_legal_type : assert property (@(posedge clk) disable iff (reset_i)
    tdata1_q[TTYPE_HI:TTYPE_LO] inside {TTYPE_MCONTROL6, TTYPE_DISABLED})
    else $error("Illegal trigger type stored in slot");

endmodule

`default_nettype wire

//--- source/trigger_readback.sv
// Trigger readback, muxes the selected slot onto the CSR read port and combines slot hits
`default_nettype none

module trigger_readback
  import dbg_trigger_pkg::*;
(
  input  wire logic       [TSEL_W-1:0]       tselect_i,
  input  wire slot_regs_t [NUM_TRIGGERS-1:0] regs_i,
  input  wire logic       [NUM_TRIGGERS-1:0] if_hits_i,
  input  wire logic       [NUM_TRIGGERS-1:0] ex_hits_i,
  output csr_rd_t                            csr_rd_o,
  output logic                               if_hit_o,
  output logic                               ex_hit_o
);

  slot_regs_t regs_sel;  // Registers of the slot named by tselect

  //////////////////////////////
  // CSR read port
  //////////////////////////////

  assign regs_sel = regs_i[tselect_i];

  assign csr_rd_o.tselect = {{(32-TSEL_W){1'b0}}, tselect_i};  // Zero-extended
  assign csr_rd_o.tdata1  = regs_sel.tdata1;
  assign csr_rd_o.tdata2  = regs_sel.tdata2;

  //////////////////////////////
  // Hit outputs
  //////////////////////////////

  // Any slot hitting raises the stage hit
  assign if_hit_o = |if_hits_i;
  assign ex_hit_o = |ex_hits_i;

endmodule

`default_nettype wire

//--- source/dbg_trigger_top.sv
// Debug trigger unit top level with the CSR write stage, the trigger slots and the readback
`default_nettype none

module dbg_trigger_top
  import dbg_trigger_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset_i,
  input  wire csr_wr_t  csr_wr_i,       // CSR write strobes and data
  input  wire fetch_t   fetch_i,        // IF stage fetch
  input  wire lsu_req_t lsu_i,          // EX stage LSU request
  input  wire logic     debug_mode_i,
  output csr_rd_t       csr_rd_o,
  output logic          if_hit_o,
  output logic          ex_hit_o
);

  slot_wr_t   [NUM_TRIGGERS-1:0] slot_wr;   // Legalized writes per slot
  slot_regs_t [NUM_TRIGGERS-1:0] slot_regs;
  logic       [NUM_TRIGGERS-1:0] if_hits;
  logic       [NUM_TRIGGERS-1:0] ex_hits;
  logic       [TSEL_W-1:0]       tselect;

  //////////////////////////////
  // CSR write stage
  //////////////////////////////

  trigger_csr_write u_trigger_csr_write (
    .clk       (clk),
    .reset_i   (reset_i),
    .csr_wr_i  (csr_wr_i),
    .slot_wr_o (slot_wr),
    .tselect_o (tselect)
  );

  //////////////////////////////
  // Trigger slots
  //////////////////////////////

  for (genvar g = 0; g < NUM_TRIGGERS; g++) begin : gen_slot
    trigger_slot u_trigger_slot (
      .clk          (clk),
      .reset_i      (reset_i),
      .slot_wr_i    (slot_wr[g]),
      .fetch_i      (fetch_i),
      .lsu_i        (lsu_i),
      .debug_mode_i (debug_mode_i),
      .regs_o       (slot_regs[g]),
      .if_hit_o     (if_hits[g]),
      .ex_hit_o     (ex_hits[g])
    );
  end

  // Read port and hit combining
  trigger_readback u_trigger_readback (
    .tselect_i (tselect),
    .regs_i    (slot_regs),
    .if_hits_i (if_hits),
    .ex_hits_i (ex_hits),
    .csr_rd_o  (csr_rd_o),
    .if_hit_o  (if_hit_o),
    .ex_hit_o  (ex_hit_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset source, 10 ns clock with reset held for the first 4 cycles
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  // Four rising edges inside reset
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/dbg_trigger_tb.sv
// Testbench for the debug trigger unit that replays the tests file against the DUT and checks results
`default_nettype none

module dbg_trigger_tb
  import dbg_trigger_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic     clk;
  logic     reset;
  csr_wr_t  csr_wr;
  fetch_t   fetch;
  lsu_req_t lsu;
  logic     debug_mode;
  csr_rd_t  csr_rd;
  logic     if_hit;
  logic     ex_hit;

  int fd;
  int line_count  = 0;
  int limit       = 0;  // Zero until the tests file is measured
  int cycles      = 0;

  tb_clock_gen u_tb_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  dbg_trigger_top u_dbg_trigger_top (
    .clk          (clk),
    .reset_i      (reset),
    .csr_wr_i     (csr_wr),
    .fetch_i      (fetch),
    .lsu_i        (lsu),
    .debug_mode_i (debug_mode),
    .csr_rd_o     (csr_rd),
    .if_hit_o     (if_hit),
    .ex_hit_o     (ex_hit)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Quiet bus with a pointer fetch so the IF side never hits
  task automatic drive_idle();
    csr_wr     = '0;
    fetch.pc   = 32'h0;
    fetch.ptr  = 1'b1;
    fetch.priv = PRIV_M;
    lsu        = '0;
    debug_mode = 1'b0;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s expected %08h got %08h", $time, what, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Stopping at the first failed check");
    end
  endtask

  // Watchdog sized from the tests file
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    string       line;
    byte         op;
    logic [31:0] field [6];
    int          n;
    int          idle;
    int          line_no;
    drive_idle();
    void'($urandom(32'hb0d00bb2));  // Fixed seed for the idle gaps
    fd = $fopen("verification/dbg_trigger_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the tests file verification/dbg_trigger_tests.txt");
      $display("Finished with errors");
      $fatal(1, "Missing tests file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) line_count++;
    end
    $fclose(fd);
    limit   = 4 * line_count + 40;  // Op plus at most two idle cycles per line
    fd      = $fopen("verification/dbg_trigger_tests.txt", "r");
    line_no = 0;
    @(negedge clk);
    while (reset !== 1'b0) @(negedge clk);
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      line_no++;
      if (n < 2 || line[0] == "#") continue;  // Blank or comment
      n = $sscanf(line, "%c %h %h %h %h %h %h", op, field[0], field[1], field[2],
                  field[3], field[4], field[5]);
      @(negedge clk);
      drive_idle();
      idle = int'($urandom % 3);
      repeat (idle) @(negedge clk);
      case (op)
        "W": begin
          csr_wr.wdata = field[1];
          case (field[0])
            0:       csr_wr.tselect_we = 1'b1;
            1:       csr_wr.tdata1_we  = 1'b1;
            2:       csr_wr.tdata2_we  = 1'b1;
            default: begin
              $display("Line %0d has an unknown CSR kind", line_no);
              $display("Finished with errors");
              $fatal(1, "Bad tests file");
            end
          endcase
        end
        "R": begin
          #4;  // Just before the next rising edge
          check_value(csr_rd.tselect, field[0], $sformatf("line %0d tselect", line_no));
          check_value(csr_rd.tdata1, field[1], $sformatf("line %0d tdata1", line_no));
          check_value(csr_rd.tdata2, field[2], $sformatf("line %0d tdata2", line_no));
        end
        "F": begin
          fetch.pc   = field[0];
          fetch.ptr  = field[1][0];
          fetch.priv = priv_e'(field[2][1:0]);
          debug_mode = field[3][0];
          #4;
          check_value({31'b0, if_hit}, field[4], $sformatf("line %0d if_hit", line_no));
        end
        "L": begin
          lsu.valid  = 1'b1;
          lsu.addr   = field[0];
          lsu.we     = field[1][0];
          lsu.be     = field[2][3:0];
          lsu.priv   = priv_e'(field[3][1:0]);
          debug_mode = field[4][0];
          #4;
          check_value({31'b0, ex_hit}, field[5], $sformatf("line %0d ex_hit", line_no));
        end
        default: begin
          $display("Line %0d has an unknown operation", line_no);
          $display("Finished with errors");
          $fatal(1, "Bad tests file");
        end
      endcase
    end
    $fclose(fd);
    @(negedge clk);
    drive_idle();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- dbg_trigger.f
source/dbg_trigger_pkg.sv
source/trigger_csr_write.sv
source/trigger_slot.sv
source/trigger_readback.sv
source/dbg_trigger_top.sv
verification/tb_clock_gen.sv
verification/dbg_trigger_tb.sv

//--- verification/dbg_trigger_tests.txt
# W kind(0 tselect 1 tdata1 2 tdata2) wdata | R tselect tdata1 tdata2
# F pc ptr priv dbg if_hit | L addr we be priv dbg ex_hit  (all hex, priv 0 U 3 M)
R 00000000 F8000000 00000000
W 0 00000003
R 00000003 F8000000 00000000
W 0 00000007
R 00000003 F8000000 00000000
W 1 20000FFF
R 00000003 F8000000 00000000
W 1 67F070DF
W 2 00001000
R 00000003 6800104F 00001000
F 00001000 0 3 0 1
F 00001004 0 3 0 0
F 00001000 1 3 0 0
F 00001000 0 3 1 0
L 00001000 0 1 3 0 1
L 00001000 0 E 3 0 0
L 00001000 1 1 3 1 0
W 0 00000000
R 00000000 F8000000 00000000
W 1 60000144
W 2 00002000
R 00000000 68001144 00002000
F 00002000 0 3 0 1
F 00002000 0 0 0 0
F 00001FFC 0 3 0 0
W 0 00000001
W 1 6000018A
W 2 00003002
R 00000001 6800118A 00003002
L 00003000 1 C 0 0 0
L 00003000 1 6 0 0 1
L 00003000 0 2 0 0 0
L 00003000 1 2 3 0 0
F 00003000 0 0 0 0
W 0 00000002
W 1 60000141
W 2 00004003
R 00000002 68001141 00004003
L 00004000 0 7 3 0 0
L 00004000 0 9 3 0 1
L 00004000 1 8 3 0 0
L 00005000 0 F 3 1 0
W 0 00000003
W 2 00002000
F 00002000 0 3 0 1
F 00002000 0 0 0 1
F 00002000 0 3 1 0
W 0 00000000
W 1 F0000000
R 00000000 F8000000 00002000
F 00002000 0 3 0 1
W 0 00000003
W 1 00000000
R 00000003 F8000000 00002000
F 00002000 0 3 0 0
F 00002000 0 0 0 0
